// File: Makefile
# Verilator simulation of the I2S transmitter

TOP = tb_i2s_tx

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
+incdir+.
i2s_pkg.sv
i2s_clk_gen.sv
sample_fifo.sv
i2s_serializer.sv
i2s_tx_top.sv
tb_i2s_tx.sv

// File: i2s_clk_gen.sv
`timescale 1ns/1ps
`include "i2s_consts.svh"

module i2s_clk_gen (
	input  logic bclk,
	input  logic rst,
	output logic sck,
	output logic sck_rise,
	output logic sck_fall
);

	localparam int HALF = `I2S_SCK_HALF;
	localparam int CW = (HALF > 1) ? $clog2(HALF) : 1;
	localparam logic [CW-1:0] RELOAD = CW'(HALF - 1);

	logic [CW-1:0] cnt;  // bclk cycles left in this half-period
	logic          edge_now;

	assign edge_now = (cnt == '0);

	// ========================================
	// divider and edge strobes
	// ========================================

	// strobes register together with sck, so each one is
	// high in exactly the cycle where sck shows its new level
	always_ff @(posedge bclk) begin
		if (!rst) begin
			cnt      <= RELOAD;
			sck      <= 1'b0;
			sck_rise <= 1'b0;
			sck_fall <= 1'b0;
		end else begin
			if (edge_now) begin
				cnt <= RELOAD;
				sck <= !sck;
			end else begin
				cnt <= cnt - CW'(1);
			end
			sck_rise <= edge_now && !sck;  // going 0 -> 1
			sck_fall <= edge_now && sck;   // going 1 -> 0
		end
	end

	// ========================================
	// checks
	// ========================================

	a_edges_exclusive: assert property (
		@(posedge bclk) disable iff (!rst)
		!(sck_rise && sck_fall)
	) else $error("sck_rise and sck_fall high together");

	// high phase lasts exactly HALF bclk cycles
	a_high_phase: assert property (
		@(posedge bclk) disable iff (!rst)
		sck_rise |-> ##HALF sck_fall
	) else $error("sck high phase has wrong length");

endmodule

// File: i2s_consts.svh
`ifndef I2S_CONSTS_SVH
`define I2S_CONSTS_SVH

// ========================================
// I2S transmitter build constants
// ========================================

// bits per channel word, 16 to 31
`define I2S_SAMPLE_W 24

// sck periods per channel half-frame
`define I2S_HALF_SLOTS 32

// bclk cycles per sck half-period, 1 or more
`define I2S_SCK_HALF 2

// stereo frames held by the sample FIFO, power of two
`define I2S_FIFO_DEPTH 4

`endif

// File: i2s_pkg.sv
`include "i2s_consts.svh"

package i2s_pkg;

	// ========================================
	// sample data
	// ========================================

	// one stereo frame as written by the host
	typedef struct packed {
		logic [`I2S_SAMPLE_W-1:0] left;   // sent while lrclk low
		logic [`I2S_SAMPLE_W-1:0] right;  // sent while lrclk high
	} stereo_frame_t;

	// ========================================
	// serial pins
	// ========================================

	typedef struct packed {
		logic sck;    // bit clock
		logic lrclk;  // word select
		logic sdata;  // serial data, MSB first
	} i2s_pins_t;

endpackage

// File: i2s_serializer.sv
`timescale 1ns/1ps
`include "i2s_consts.svh"

module i2s_serializer (
	input  logic                   bclk,
	input  logic                   rst,
	input  logic                   sck,
	input  logic                   sck_rise,
	input  logic                   sck_fall,
	input  i2s_pkg::stereo_frame_t head,
	input  logic                   empty,
	output logic                   pop,
	output logic                   underrun,
	output i2s_pkg::i2s_pins_t     pins
);

	localparam int SW = `I2S_SAMPLE_W;
	localparam int HALF = `I2S_HALF_SLOTS;
	localparam logic [5:0] LAST_SLOT = 6'(2 * HALF - 1);
	localparam logic [5:0] RIGHT_START = 6'(HALF);

	logic [5:0]  slot;       // slot currently on the pins
	logic [5:0]  next_slot;  // slot entered at the next sck_fall
	logic [4:0]  half_idx;   // position inside the half-frame
	logic        fetch;

	logic [SW-1:0] shreg;       // MSB goes out next
	logic [SW-1:0] right_hold;  // right word waits here during left half
	logic          lrclk_q;
	logic          sdata_q;

	i2s_pkg::stereo_frame_t fetch_frame;

	assign next_slot = slot + 6'd1;  // 63 wraps to 0
	assign half_idx  = next_slot[4:0];

	// ========================================
	// frame fetch
	// ========================================

	// fetch in the sck_fall cycle that enters slot 0
	assign fetch = sck_fall && (slot == LAST_SLOT);

	assign pop      = fetch && !empty;
	assign underrun = fetch && empty;  // nothing queued, send silence

	assign fetch_frame = empty ? '0 : head;

	// ========================================
	// slot counter and pin registers
	// ========================================

	always_ff @(posedge bclk) begin
		if (!rst) begin
			slot    <= LAST_SLOT;  // first fall enters slot 0
			lrclk_q <= 1'b0;
			sdata_q <= 1'b0;
		end else if (sck_fall) begin
			slot    <= next_slot;
			lrclk_q <= (next_slot >= RIGHT_START);  // low = left
			if (half_idx == 5'd0) begin
				sdata_q <= 1'b0;  // one slot delay after lrclk edge
			end else begin
				sdata_q <= shreg[SW-1];
			end
		end
	end

	// shift path, zeros fill in behind the word so the
	// unused tail of each half-frame reads zero
	always_ff @(posedge bclk) begin
		if (sck_fall) begin
			if (fetch) begin
				shreg      <= fetch_frame.left;
				right_hold <= fetch_frame.right;
			end else if (half_idx == 5'd0) begin
				shreg <= right_hold;  // start of right half
			end else begin
				shreg <= {shreg[SW-2:0], 1'b0};
			end
		end
	end

	assign pins = '{sck: sck, lrclk: lrclk_q, sdata: sdata_q};

	// ========================================
	// checks
	// ========================================

	// the pop lines up with slot 0 and left channel select
	a_pop_at_slot0: assert property (
		@(posedge bclk) disable iff (!rst)
		pop |=> (slot == 6'd0) && !lrclk_q
	) else $error("pop outside slot 0 fetch");

	// sampled by the receiver on rising sck
	a_pad_zero: assert property (
		@(posedge bclk) disable iff (!rst)
		(sck_rise && ((slot[4:0] == 5'd0) || (32'(slot[4:0]) > SW))) |-> !sdata_q
	) else $error("sdata not zero in unused slot");

endmodule

// File: i2s_tx_top.sv
`timescale 1ns/1ps
`include "i2s_consts.svh"

module i2s_tx_top (
	input  logic                   bclk,
	input  logic                   rst,
	input  logic                   wr,
	input  i2s_pkg::stereo_frame_t wr_frame,
	output logic                   full,
	output logic                   underrun,
	output i2s_pkg::i2s_pins_t     pins
);

	// ========================================
	// internal nets
	// ========================================

	logic sck;
	logic sck_rise;
	logic sck_fall;

	i2s_pkg::stereo_frame_t head;  // oldest queued frame
	logic                   empty;
	logic                   pop;

	// ========================================
	// blocks
	// ========================================

	i2s_clk_gen clk_gen_i (
		.bclk     (bclk),
		.rst      (rst),
		.sck      (sck),
		.sck_rise (sck_rise),
		.sck_fall (sck_fall)
	);

	// host side, back-pressure through full only
	sample_fifo fifo_i (
		.bclk     (bclk),
		.rst      (rst),
		.wr       (wr),
		.wr_frame (wr_frame),
		.pop      (pop),
		.head     (head),
		.full     (full),
		.empty    (empty)
	);

	i2s_serializer ser_i (
		.bclk     (bclk),
		.rst      (rst),
		.sck      (sck),
		.sck_rise (sck_rise),
		.sck_fall (sck_fall),
		.head     (head),
		.empty    (empty),
		.pop      (pop),
		.underrun (underrun),
		.pins     (pins)
	);

endmodule

// File: sample_fifo.sv
`timescale 1ns/1ps
`include "i2s_consts.svh"

module sample_fifo (
	input  logic                   bclk,
	input  logic                   rst,
	input  logic                   wr,
	input  i2s_pkg::stereo_frame_t wr_frame,
	input  logic                   pop,
	output i2s_pkg::stereo_frame_t head,
	output logic                   full,
	output logic                   empty
);

	localparam int DEPTH = `I2S_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] PTR_ONE = {{AW{1'b0}}, 1'b1};

	i2s_pkg::stereo_frame_t mem [DEPTH];

	// top bit of each pointer is the wrap flag
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [AW:0] level;
	logic        wr_ok;

	// ========================================
	// status and read side
	// ========================================

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
		(wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign level = wr_ptr - rd_ptr;  // frames stored

	assign wr_ok = wr && !full;  // writes while full are lost

	// first word fall through, head always shows oldest entry
	assign head = mem[rd_ptr[AW-1:0]];

	// ========================================
	// storage and pointers
	// ========================================

	always_ff @(posedge bclk) begin
		if (wr_ok) begin
			mem[wr_ptr[AW-1:0]] <= wr_frame;
		end
	end

	always_ff @(posedge bclk) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + PTR_ONE;
			end
			// consumer is trusted here, see check below
			if (pop) begin
				rd_ptr <= rd_ptr + PTR_ONE;
			end
		end
	end

	// ========================================
	// checks
	// ========================================

	a_no_pop_empty: assert property (
		@(posedge bclk) disable iff (!rst)
		pop |-> !empty
	) else $error("pop while FIFO empty");

	a_level_bound: assert property (
		@(posedge bclk) disable iff (!rst)
		level <= (AW+1)'(DEPTH)
	) else $error("FIFO occupancy above depth");

endmodule

// File: tb_i2s_tx.sv
`timescale 1ns/1ps
`include "i2s_consts.svh"

module tb_i2s_tx;

	localparam int SW = `I2S_SAMPLE_W;
	localparam int HALF = `I2S_SCK_HALF;
	localparam int DEPTH = `I2S_FIFO_DEPTH;
	localparam int NUM_FIXED = 6;
	localparam int NUM_BURST = DEPTH + 2;  // two writes past full
	localparam int NUM_ROWS = NUM_FIXED + NUM_BURST;
	localparam int SCK_BCLK = 2 * HALF;    // bclk cycles per sck period
	localparam int FRAME_BCLK = 2 * `I2S_HALF_SLOTS * SCK_BCLK;
	localparam int LIMIT_NS = (NUM_ROWS + 6) * FRAME_BCLK * 40;

	localparam logic [SW-1:0] ONES = '1;
	localparam logic [SW-1:0] ZERO = '0;
	localparam logic [SW-1:0] MSB_ONLY = {1'b1, {(SW-1){1'b0}}};

	typedef struct packed {
		i2s_pkg::stereo_frame_t frame;
		logic                   burst;  // written in the overflow phase
		logic                   kept;   // FIFO has room for it
	} row_t;

	typedef struct packed {
		i2s_pkg::stereo_frame_t frame;
		logic                   under;  // fetched from an empty FIFO
	} decoded_t;

	logic                   bclk;
	logic                   rst;
	logic                   wr;
	i2s_pkg::stereo_frame_t wr_frame;
	logic                   full;
	logic                   underrun;
	i2s_pkg::i2s_pins_t     pins;

	integer                 seed;
	row_t                   table_rows [NUM_ROWS];
	decoded_t               exp_q [$];  // frames in the order they go out
	decoded_t               dec_q [$];
	logic                   check_done;

	// pin decoder state
	logic          prev_sck;
	logic          started;
	logic          seen_rise;
	logic          cur_under;
	logic [5:0]    mon_slot;
	int            cyc_since;
	logic [SW-1:0] word_l;
	logic [SW-1:0] word_r;

	i2s_tx_top dut_i (
		.bclk     (bclk),
		.rst      (rst),
		.wr       (wr),
		.wr_frame (wr_frame),
		.full     (full),
		.underrun (underrun),
		.pins     (pins)
	);

	initial bclk = 1'b0;
	always #20 bclk = !bclk;

	// ========================================
	// helpers
	// ========================================

	task automatic check_val(input string name, input logic [63:0] got,
		input logic [63:0] want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
				$time, name, got, want);
			$display("Test FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	function automatic logic [SW-1:0] alt_bits(input logic first);
		logic [SW-1:0] w;
		logic          b;
		int            i;
		b = first;  // value of the MSB
		for (i = SW - 1; i >= 0; i--) begin
			w[i] = b;
			b    = !b;
		end
		return w;
	endfunction

	function automatic row_t make_row(input logic [SW-1:0] l, input logic [SW-1:0] r,
		input logic burst, input logic kept);
		row_t row;
		row.frame.left  = l;
		row.frame.right = r;
		row.burst       = burst;
		row.kept        = kept;
		return row;
	endfunction

	task automatic fill_table();
		int            i;
		logic [SW-1:0] l;
		logic [SW-1:0] r;
		table_rows[0] = make_row(ONES, ONES, 1'b0, 1'b1);
		table_rows[1] = make_row(alt_bits(1'b1), alt_bits(1'b0), 1'b0, 1'b1);
		table_rows[2] = make_row(MSB_ONLY, ZERO, 1'b0, 1'b1);
		table_rows[3] = make_row(ZERO, MSB_ONLY, 1'b0, 1'b1);
		table_rows[4] = make_row(ZERO, ZERO, 1'b0, 1'b1);
		table_rows[5] = make_row(alt_bits(1'b0), ONES, 1'b0, 1'b1);
		// burst rows, the last two land while full
		for (i = 0; i < NUM_BURST; i++) begin
			l = SW'($random(seed));
			r = SW'($random(seed));
			table_rows[NUM_FIXED + i] = make_row(l, r, 1'b1, i < DEPTH);
		end
	endtask

	task automatic check_reset_outputs();
		check_val("pins.sck", 64'(pins.sck), 64'd0);
		check_val("pins.lrclk", 64'(pins.lrclk), 64'd0);
		check_val("pins.sdata", 64'(pins.sdata), 64'd0);
		check_val("full", 64'(full), 64'd0);
		check_val("underrun", 64'(underrun), 64'd0);
	endtask

	// host write, holds off while the FIFO is full
	task automatic write_frame(input i2s_pkg::stereo_frame_t f);
		while (full) begin
			@(posedge bclk);
			#2;
		end
		wr       = 1'b1;
		wr_frame = f;
		@(posedge bclk);
		#2;
		wr = 1'b0;
	endtask

	// ========================================
	// stimulus
	// ========================================

	initial begin
		int       i;
		decoded_t want;
		seed     = 32'hc032;
		rst      = 1'b0;
		wr       = 1'b0;
		wr_frame = '0;
		fill_table();
		// fixed rows, then the silent frame that ends the drain
		want.under = 1'b0;
		for (i = 0; i < NUM_ROWS; i++) begin
			if (!table_rows[i].burst) begin
				want.frame = table_rows[i].frame;
				exp_q.push_back(want);
			end
		end
		want.frame = '0;
		want.under = 1'b1;
		exp_q.push_back(want);
		// burst rows that fit, then silence once drained again
		want.under = 1'b0;
		for (i = 0; i < NUM_ROWS; i++) begin
			if (table_rows[i].burst && table_rows[i].kept) begin
				want.frame = table_rows[i].frame;
				exp_q.push_back(want);
			end
		end
		want.frame = '0;
		want.under = 1'b1;
		exp_q.push_back(want);
		for (i = 0; i < 10; i++) begin
			@(posedge bclk);
			#2;
			check_reset_outputs();
		end
		rst = 1'b1;
		for (i = 0; i < NUM_ROWS; i++) begin
			if (!table_rows[i].burst) begin
				write_frame(table_rows[i].frame);
			end
		end
		// drain until a fetch finds nothing queued
		@(posedge bclk);
		#2;
		while (!underrun) begin
			@(posedge bclk);
			#2;
		end
		@(posedge bclk);  // fetch edge
		#2;
		for (i = 0; i < NUM_ROWS; i++) begin
			if (table_rows[i].burst) begin
				check_val("full", 64'(full), 64'(!table_rows[i].kept));
				wr       = 1'b1;  // back to back, no wait on full
				wr_frame = table_rows[i].frame;
				@(posedge bclk);
				#2;
			end
		end
		wr = 1'b0;
		while (!check_done) begin
			@(posedge bclk);
		end
		$display("Test OK");
		$finish;
	end

	initial begin
		#(LIMIT_NS);
		$display("timeout: the run did not finish within %0d ns", LIMIT_NS);
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

	// ========================================
	// pin decoder, samples mid-cycle
	// ========================================

	always @(negedge bclk) begin : decode_pins
		int       pos;
		logic     fell;
		decoded_t item;
		if (!rst) begin
			prev_sck  = 1'b0;
			started   = 1'b0;
			seen_rise = 1'b0;
			cur_under = 1'b0;
			mon_slot  = 6'd63;  // first fall enters slot 0
			cyc_since = 0;
		end else begin
			cyc_since = cyc_since + 1;
			fell = !pins.sck && prev_sck;
			if (fell) begin
				mon_slot = mon_slot + 6'd1;
				started  = 1'b1;
			end
			if (fell && (mon_slot == 6'd0)) begin
				cur_under = underrun;
			end else begin
				check_val("underrun", 64'(underrun), 64'd0);  // only at a fetch
			end
			if (pins.sck && !prev_sck) begin
				if (seen_rise) begin
					check_val("sck period", 64'(cyc_since), 64'(SCK_BCLK));
				end
				seen_rise = 1'b1;
				cyc_since = 0;
				if (started) begin
					check_val("pins.lrclk", 64'(pins.lrclk), 64'(mon_slot >= 6'd32));
					pos = int'(mon_slot[4:0]);
					if ((pos >= 1) && (pos <= SW)) begin
						if (mon_slot[5]) begin
							word_r = {word_r[SW-2:0], pins.sdata};
						end else begin
							word_l = {word_l[SW-2:0], pins.sdata};
						end
					end else begin
						check_val("pins.sdata", 64'(pins.sdata), 64'd0);
					end
					if (mon_slot == 6'd63) begin
						item.frame.left  = word_l;
						item.frame.right = word_r;
						item.under       = cur_under;
						dec_q.push_back(item);
					end
				end
			end
			prev_sck = pins.sck;
		end
	end

	// ========================================
	// compare decoded frames
	// ========================================

	initial begin : compare_frames
		decoded_t item;
		decoded_t want;
		check_done = 1'b0;
		while (!check_done) begin
			while (dec_q.size() == 0) begin
				@(negedge bclk);
			end
			item = dec_q.pop_front();
			want = exp_q.pop_front();
			check_val("underrun at fetch", 64'(item.under), 64'(want.under));
			check_val("left word", 64'(item.frame.left), 64'(want.frame.left));
			check_val("right word", 64'(item.frame.right), 64'(want.frame.right));
			if (exp_q.size() == 0) begin
				check_done = 1'b1;
			end
		end
	end

endmodule
